// ==== vlog.f ====
+incdir+verif
rtl/decode_pkg.sv
rtl/id_stage_reg.sv
rtl/inst_decoder.sv
rtl/operand_read.sv
rtl/decode_stage.sv
verif/decode_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module decode_stage_tb -f vlog.f -o decode_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/decode_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

// ==== verif/decode_ref.svh ====
// Reference decode and stimulus
`ifndef decode_ref_svh
`define decode_ref_svh

localparam op_t reg_ops [8] = '{op_add, op_sll, op_slt, op_sltu, op_xor, op_srl, op_or, op_and};
localparam op_t imm_ops [8] = '{op_addi, op_slli, op_slti, op_sltiu, op_xori, op_srli,
                                op_ori, op_andi};
localparam op_t load_ops [8] = '{op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu, op_none};
localparam op_t store_ops [4] = '{op_sb, op_sh, op_sw, op_sd};
localparam op_t branch_ops [8] = '{op_beq, op_bne, op_none, op_none, op_blt, op_bge,
                                   op_bltu, op_bgeu};
localparam alu_mode_t f3_modes [8] = '{alu_add, alu_sll, alu_slt, alu_sltu, alu_xor,
                                       alu_srl, alu_or, alu_and};
localparam logic [6:0] opcodes [12] = '{7'b0110011, 7'b0111011, 7'b0010011, 7'b0011011,
                                        7'b0000011, 7'b0100011, 7'b1100011, 7'b1100111,
                                        7'b1101111, 7'b0110111, 7'b0010111, 7'b1110011};

// expected issue word; uses is {rs1, rs2}
function automatic issue_t ref_issue(input xword_t pc, input inst_t inst,
                                     input gpr_file_t gpr, output logic [1:0] uses);
    logic [2:0] f3;
    logic       alt;
    logic       shift;
    xword_t     rs1;
    xword_t     rs2;
    xword_t     imm_i;
    xword_t     imm_u;
    issue_t     r;
    f3 = inst[14:12];
    alt = inst[30];
    shift = (f3 == 3'd1) || (f3 == 3'd5);
    rs1 = gpr[inst[19:15]];
    rs2 = gpr[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h0};
    r = '{op: op_none, rd: inst[11:7], wen: 1'b0, alu_mode: alu_add, a: rs1, b: imm_i,
          store_data: rs2, pc: pc, inst: inst};
    uses = 2'b10;
    case (inst[6:0])
        7'b0110011: if (inst[31:25] == 7'h00 ||
                        (inst[31:25] == 7'h20 && f3 inside {3'd0, 3'd5})) begin
            r.op = alt ? ((f3 == 3'd0) ? op_sub : op_sra) : reg_ops[f3];
            r.b = (shift && !alt) ? (rs2 & 64'h3f) : rs2; // only sll and srl mask
            uses = 2'b11;
        end
        7'b0111011: if ((inst[31:25] == 7'h00 && f3 inside {3'd0, 3'd1, 3'd5}) ||
                        (inst[31:25] == 7'h20 && f3 inside {3'd0, 3'd5})) begin
            r.op = (f3 == 3'd0) ? (alt ? op_subw : op_addw)
                                : ((f3 == 3'd1) ? op_sllw : (alt ? op_sraw : op_srlw));
            r.a = (f3 == 3'd5) ? {rs1[31:0], 32'h0} : rs1; // word in upper half
            r.b = (f3 == 3'd0) ? rs2 : (rs2 & 64'h1f);
            uses = 2'b11;
        end
        7'b0010011: if (!shift || inst[31:26] == 6'h00 ||
                        (f3 == 3'd5 && inst[31:26] == 6'h10)) begin
            r.op = (f3 == 3'd5 && alt) ? op_srai : imm_ops[f3];
            r.b = shift ? (imm_i & 64'h3f) : imm_i;
        end
        7'b0011011: if (f3 == 3'd0 || (shift && (inst[31:25] == 7'h00 ||
                                       (f3 == 3'd5 && inst[31:25] == 7'h20)))) begin
            r.op = (f3 == 3'd0) ? op_addiw
                                : ((f3 == 3'd1) ? op_slliw : (alt ? op_sraiw : op_srliw));
            r.a = (f3 == 3'd5 && alt) ? {rs1[31:0], 32'h0}
                                      : ((f3 == 3'd0) ? rs1 : {32'h0, rs1[31:0]});
            r.b = shift ? (imm_i & 64'h1f) : imm_i;
        end
        7'b0000011: if (f3 != 3'd7) r.op = load_ops[f3];
        7'b0100011: if (!f3[2]) begin
            r.op = store_ops[f3[1:0]];
            r.b = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            uses = 2'b11;
        end
        7'b1100011: if (branch_ops[f3] != op_none) begin
            r.op = branch_ops[f3];
            r.b = rs2;
            uses = 2'b11;
        end
        7'b1100111: if (f3 == 3'd0) r.op = op_jalr;
        7'b1101111: begin
            r.op = op_jal;
            r.a = pc;
            r.b = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            uses = 2'b00;
        end
        7'b0110111: begin
            r.op = op_lui;
            r.a = imm_u;
            r.b = '0;
            uses = 2'b00;
        end
        7'b0010111: begin
            r.op = op_auipc;
            r.a = pc;
            r.b = imm_u;
            uses = 2'b00;
        end
        default: ;
    endcase
    if (r.op == op_none) begin
        r.a = '0;
        r.b = '0;
        uses = 2'b00;
    end else begin
        r.wen = !(inst[6:0] inside {7'b1100011, 7'b0100011});
        if (inst[6:0] == 7'b1100011) begin
            r.alu_mode = alu_sub;
        end else if (inst[4] && !inst[2]) begin // the four ALU opcodes
            r.alu_mode = f3_modes[f3];
            if (alt && f3 == 3'd5) r.alu_mode = alu_sra;
            if (alt && f3 == 3'd0 && inst[5]) r.alu_mode = alu_sub;
        end
    end
    return r;
endfunction

// random fields over every opcode class, plus mul, system and illegal words
function automatic inst_t random_inst();
    inst_t w;
    w = $urandom;
    w[6:0] = opcodes[4'($urandom_range(11))];
    case ($urandom_range(4))
        0: w[31:26] = 6'h00;
        1: w[31:26] = 6'h10;
        2: w[31:25] = 7'h01; // mul/div group
        3: w[6:0] = 7'b1111111;
        default: ;
    endcase
    if (w[6:0] == 7'b1110011 && w[12]) w = 32'h0000_0073; // ecall
    return w;
endfunction

`endif

// ==== verif/decode_stage_tb.sv ====
// Decode stage testbench
module decode_stage_tb import decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    `include "decode_ref.svh"

    localparam int num_insts = 1500;
    localparam int max_cycles = 20000; // 1500 insts at up to 6 stalled cycles, plus reset

    logic       clk = 1'b0;
    logic       rst;
    logic       in_valid;
    fetch_t     fetch_in;
    logic       in_ready;
    gpr_file_t  gpr;
    reg_mask_t  gpr_busy;
    logic       out_valid;
    issue_t     issue_out;

    fetch_t     pending [$]; // accepted, not yet issued
    fetch_t     head;
    logic       head_valid = 1'b0;
    issue_t     exp_issue;
    logic [1:0] exp_uses;
    logic       hazard = 1'b0;
    int         cycles = 0;
    int         sent = 0;

    decode_stage decode_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in        (fetch_in),
        .in_ready  (in_ready),
        .gpr       (gpr),
        .gpr_busy  (gpr_busy),
        .out_valid (out_valid),
        .out       (issue_out)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_failed(input string msg);
        stop_with_failure($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == max_cycles) stop_with_failure("timeout: instructions stopped issuing");
    end

    // outputs are checked mid-cycle, away from both edges
    a_empty_stage: assert property (@(negedge clk) disable iff (rst)
        !head_valid |-> !out_valid && in_ready)
        else check_failed("empty stage shows out_valid or low in_ready");
    a_stall: assert property (@(negedge clk) disable iff (rst)
        head_valid |-> out_valid == !hazard && in_ready == !hazard)
        else check_failed($sformatf("stall mismatch, out_valid=%b hazard=%b inst=%h",
                                    out_valid, hazard, head.inst));
    a_fields: assert property (@(negedge clk) disable iff (rst)
        out_valid |-> issue_out.op == exp_issue.op && issue_out.rd == exp_issue.rd &&
                      issue_out.wen == exp_issue.wen && issue_out.alu_mode == exp_issue.alu_mode)
        else check_failed($sformatf("inst %h gives op %s mode %0d, expected op %s mode %0d",
                                    head.inst, issue_out.op.name(), issue_out.alu_mode,
                                    exp_issue.op.name(), exp_issue.alu_mode));
    a_operands: assert property (@(negedge clk) disable iff (rst)
        out_valid |-> issue_out.a == exp_issue.a && issue_out.b == exp_issue.b)
        else check_failed($sformatf("inst %h gives a=%h b=%h, expected a=%h b=%h", head.inst,
                                    issue_out.a, issue_out.b, exp_issue.a, exp_issue.b));
    a_pass_through: assert property (@(negedge clk) disable iff (rst)
        out_valid |-> issue_out.store_data == exp_issue.store_data &&
                      issue_out.pc == exp_issue.pc && issue_out.inst == exp_issue.inst)
        else check_failed($sformatf("pc %h inst %h issued, expected pc %h inst %h",
                                    issue_out.pc, issue_out.inst, head.pc, head.inst));

    initial begin
        xword_t    next_pc;
        logic      accepted;
        logic      issued;
        int        busy_left;
        reg_mask_t busy_mask;
        int        i;
        void'($urandom(32'h1385_5272));
        next_pc = 64'h0000_0000_8000_0000;
        busy_left = 0;
        busy_mask = '0;
        rst = 1'b1;
        in_valid = 1'b0;
        fetch_in = '0;
        gpr = '0;
        gpr_busy = '0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        while (sent < num_insts || head_valid) begin
            @(negedge clk);
            accepted = in_valid && in_ready;
            issued = out_valid;
            @(posedge clk);
            if (issued) begin
                void'(pending.pop_front());
            end
            if (accepted) begin
                pending.push_back(fetch_in);
                sent++;
            end
            #1;
            if (accepted || !in_valid) begin // fetch holds a waiting instruction
                in_valid = (sent < num_insts) && ($urandom_range(7) != 0);
                fetch_in.pc = next_pc;
                fetch_in.inst = random_inst();
                next_pc = next_pc + 64'd4;
            end
            for (i = 0; i < num_regs; i++) begin
                gpr[i] = {$urandom, $urandom};
            end
            if (busy_left == 0) begin // next busy burst, 0 to 5 cycles
                busy_left = $urandom_range(5);
                busy_mask = $urandom & $urandom;
            end else begin
                busy_left--;
            end
            gpr_busy = (busy_left > 0) ? busy_mask : '0;
            head_valid = pending.size() > 0;
            if (head_valid) begin
                head = pending[0];
            end else begin
                head = '0;
            end
            exp_issue = ref_issue(head.pc, head.inst, gpr, exp_uses);
            hazard = head_valid && ((exp_uses[1] && gpr_busy[head.inst[19:15]]) ||
                                    (exp_uses[0] && gpr_busy[head.inst[24:20]]));
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== rtl/decode_stage.sv ====
// RV64I instruction decode stage
module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  fetch_t    in,
    output logic      in_ready,
    input  gpr_file_t gpr,
    input  reg_mask_t gpr_busy,
    output logic      out_valid,
    output issue_t    out
);

    logic     stage_valid;
    fetch_t   stage;
    decoded_t dec;
    logic     stall;

    assign in_ready = !stall; // fetch waits while decode holds

    id_stage_reg stage_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in          (in),
        .stall       (stall),
        .stage_valid (stage_valid),
        .stage       (stage)
    );

    inst_decoder decoder_inst (
        .inst (stage.inst),
        .dec  (dec)
    );

    operand_read operand_read_inst (
        .stage_valid (stage_valid),
        .pc          (stage.pc),
        .inst        (stage.inst),
        .dec         (dec),
        .gpr         (gpr),
        .gpr_busy    (gpr_busy),
        .stall       (stall),
        .out_valid   (out_valid),
        .out         (out)
    );

endmodule

// ==== rtl/operand_read.sv ====
// Register read, hazard check and ALU operands
module operand_read import decode_pkg::*; (
    input  logic      stage_valid,
    input  xword_t    pc,
    input  inst_t     inst,
    input  decoded_t  dec,
    input  gpr_file_t gpr,
    input  reg_mask_t gpr_busy,
    output logic      stall,
    output logic      out_valid,
    output issue_t    out
);

    xword_t rs1_val;
    xword_t rs2_val;
    xword_t opa;
    xword_t opb;
    logic   rs1_hazard;
    logic   rs2_hazard;

    assign rs1_val = gpr[dec.rs1];
    assign rs2_val = gpr[dec.rs2];

    // only sources the instruction reads can hold it
    assign rs1_hazard = dec.use_rs1 && gpr_busy[dec.rs1];
    assign rs2_hazard = dec.use_rs2 && gpr_busy[dec.rs2];

    assign stall     = stage_valid && (rs1_hazard || rs2_hazard);
    assign out_valid = stage_valid && !stall;

    always_comb begin
        case (dec.a_sel)
            a_rs1:      opa = rs1_val;
            a_rs1_hi:   opa = {rs1_val[31:0], 32'b0};
            a_rs1_zext: opa = {32'b0, rs1_val[31:0]};
            a_pc:       opa = pc; // pc of the held instruction
            a_imm:      opa = dec.imm;
            default:    opa = '0;
        endcase
    end

    always_comb begin
        case (dec.b_sel)
            b_rs2:    opb = rs2_val;
            b_rs2_6:  opb = {{(xlen-6){1'b0}}, rs2_val[5:0]};
            b_rs2_5:  opb = {{(xlen-5){1'b0}}, rs2_val[4:0]};
            b_shamt6: opb = {{(xlen-6){1'b0}}, dec.imm[5:0]}; // shamt is imm_i low bits
            b_shamt5: opb = {{(xlen-5){1'b0}}, dec.imm[4:0]};
            b_imm:    opb = dec.imm;
            default:  opb = '0;
        endcase
    end

    assign out = '{op: dec.op, rd: dec.rd, wen: dec.wen, alu_mode: dec.alu_mode,
                   a: opa, b: opb, store_data: rs2_val, pc: pc, inst: inst};

endmodule

// ==== rtl/inst_decoder.sv ====
// RV64I instruction decoder
module inst_decoder import decode_pkg::*; (
    input  inst_t    inst,
    output decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_t        op;
    alu_mode_t  alu_mode;
    a_sel_t     a_sel;
    b_sel_t     b_sel;
    xword_t     imm_i, imm_s, imm_u, imm_j;
    xword_t     imm;
    logic       is_rr, is_branch, is_store;
    logic       wen, use_rs1, use_rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op = op_none; // anything unmatched stays op_none
        case (opcode)
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = op_add;
                    10'b0100000_000: op = op_sub;
                    10'b0000000_001: op = op_sll;
                    10'b0000000_010: op = op_slt;
                    10'b0000000_011: op = op_sltu;
                    10'b0000000_100: op = op_xor;
                    10'b0000000_101: op = op_srl;
                    10'b0100000_101: op = op_sra;
                    10'b0000000_110: op = op_or;
                    10'b0000000_111: op = op_and;
                    default: ; // mul/div land here
                endcase
            end
            7'b0010011: begin
                case (funct3)
                    3'b000: op = op_addi;
                    3'b010: op = op_slti;
                    3'b011: op = op_sltiu;
                    3'b100: op = op_xori;
                    3'b110: op = op_ori;
                    3'b111: op = op_andi;
                    3'b001: op = (inst[31:26] == 6'b000000) ? op_slli : op_none;
                    default: begin
                        if (inst[31:26] == 6'b000000) op = op_srli;
                        else if (inst[31:26] == 6'b010000) op = op_srai;
                    end
                endcase
            end
            7'b0111011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = op_addw;
                    10'b0100000_000: op = op_subw;
                    10'b0000000_001: op = op_sllw;
                    10'b0000000_101: op = op_srlw;
                    10'b0100000_101: op = op_sraw;
                    default: ;
                endcase
            end
            7'b0011011: begin
                case ({funct7, funct3})
                    10'b0000000_001: op = op_slliw;
                    10'b0000000_101: op = op_srliw;
                    10'b0100000_101: op = op_sraiw;
                    default: op = (funct3 == 3'b000) ? op_addiw : op_none;
                endcase
            end
            7'b0000011: begin
                case (funct3)
                    3'b000: op = op_lb;
                    3'b001: op = op_lh;
                    3'b010: op = op_lw;
                    3'b011: op = op_ld;
                    3'b100: op = op_lbu;
                    3'b101: op = op_lhu;
                    3'b110: op = op_lwu;
                    default: ;
                endcase
            end
            7'b0100011: begin
                case (funct3)
                    3'b000: op = op_sb;
                    3'b001: op = op_sh;
                    3'b010: op = op_sw;
                    3'b011: op = op_sd;
                    default: ;
                endcase
            end
            7'b1100011: begin
                case (funct3)
                    3'b000: op = op_beq;
                    3'b001: op = op_bne;
                    3'b100: op = op_blt;
                    3'b101: op = op_bge;
                    3'b110: op = op_bltu;
                    3'b111: op = op_bgeu;
                    default: ;
                endcase
            end
            7'b1100111: op = (funct3 == 3'b000) ? op_jalr : op_none;
            7'b1101111: op = op_jal;
            7'b0110111: op = op_lui;
            7'b0010111: op = op_auipc;
            default: ; // system ops and illegal words
        endcase
    end

    assign is_rr = op inside {op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl,
                              op_sra, op_or, op_and, op_addw, op_subw, op_sllw, op_srlw,
                              op_sraw};
    assign is_branch = op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    assign is_store  = op inside {op_sb, op_sh, op_sw, op_sd};

    assign wen     = !(is_branch || is_store || op == op_none);
    assign use_rs1 = !(op inside {op_lui, op_auipc, op_jal, op_none});
    assign use_rs2 = is_rr || is_branch || is_store;

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (op)
            op_lui, op_auipc: imm = imm_u;
            op_jal:           imm = imm_j;
            default:          imm = is_store ? imm_s : imm_i;
        endcase
    end

    always_comb begin
        case (op)
            op_sub, op_subw, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
                alu_mode = alu_sub; // branches compare by subtraction
            op_sll, op_slli, op_sllw, op_slliw: alu_mode = alu_sll;
            op_srl, op_srli, op_srlw, op_srliw: alu_mode = alu_srl;
            op_sra, op_srai, op_sraw, op_sraiw: alu_mode = alu_sra;
            op_slt, op_slti:   alu_mode = alu_slt;
            op_sltu, op_sltiu: alu_mode = alu_sltu;
            op_xor, op_xori:   alu_mode = alu_xor;
            op_or, op_ori:     alu_mode = alu_or;
            op_and, op_andi:   alu_mode = alu_and;
            default:           alu_mode = alu_add;
        endcase
    end

    always_comb begin
        case (op)
            op_none:                    a_sel = a_zero;
            op_lui:                     a_sel = a_imm;
            op_auipc, op_jal:           a_sel = a_pc;
            op_srlw, op_sraw, op_sraiw: a_sel = a_rs1_hi; // word sits in upper half
            op_slliw, op_srliw:         a_sel = a_rs1_zext;
            default:                    a_sel = a_rs1;
        endcase
    end

    always_comb begin
        case (op)
            op_none, op_lui:             b_sel = b_zero;
            op_sll, op_srl:              b_sel = b_rs2_6;
            op_sllw, op_srlw, op_sraw:   b_sel = b_rs2_5;
            op_slli, op_srli, op_srai:   b_sel = b_shamt6;
            op_slliw, op_srliw, op_sraiw: b_sel = b_shamt5;
            default:                     b_sel = (is_rr || is_branch) ? b_rs2 : b_imm;
        endcase
    end

    assign dec = '{op: op, rd: inst[11:7], rs1: inst[19:15], rs2: inst[24:20],
                   wen: wen, use_rs1: use_rs1, use_rs2: use_rs2, a_sel: a_sel,
                   b_sel: b_sel, alu_mode: alu_mode, imm: imm};

endmodule

// ==== rtl/id_stage_reg.sv ====
// Fetch to decode pipeline register
module id_stage_reg import decode_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  fetch_t in,
    input  logic   stall,
    output logic   stage_valid,
    output fetch_t stage
);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (!stall) begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !stall) begin // hold while a source is busy
            stage <= in;
        end
    end

    // a stalled instruction must still be there at the next edge
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> $stable(stage) && $stable(stage_valid)
    ) else $error("stage register changed while stalled");

endmodule

// ==== rtl/decode_pkg.sv ====
// RV64I decode stage types
package decode_pkg;

    localparam int xlen = 64;
    localparam int num_regs = 32;

    typedef logic [xlen-1:0] xword_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [num_regs-1:0] reg_mask_t;
    typedef xword_t [num_regs-1:0] gpr_file_t; // whole register file, 2048 bits

    typedef enum logic [5:0] {
        op_none,
        op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra, op_or, op_and,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli, op_srli, op_srai,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_addiw, op_slliw, op_srliw, op_sraiw,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_jal, op_jalr, op_lui, op_auipc
    } op_t;

    // numbering is what execute expects
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_mode_t;

    typedef enum logic [2:0] {
        a_zero, a_rs1, a_rs1_hi, a_rs1_zext, a_pc, a_imm
    } a_sel_t;

    typedef enum logic [2:0] {
        b_zero, b_rs2, b_rs2_6, b_rs2_5, b_shamt6, b_shamt5, b_imm
    } b_sel_t;

    typedef struct packed {
        xword_t pc;
        inst_t  inst;
    } fetch_t;

    typedef struct packed {
        op_t       op;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        logic      wen;
        logic      use_rs1;
        logic      use_rs2;
        a_sel_t    a_sel;
        b_sel_t    b_sel;
        alu_mode_t alu_mode;
        xword_t    imm;
    } decoded_t;

    typedef struct packed {
        op_t       op;
        reg_idx_t  rd;
        logic      wen;
        alu_mode_t alu_mode;
        xword_t    a;
        xword_t    b;
        xword_t    store_data;
        xword_t    pc;
        inst_t     inst;
    } issue_t;

endpackage
